// File: Makefile
TOP = tb_cache_subsystem

all: run

build:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module cache_subsystem

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: list.f
source/cache_pkg.sv
source/cache_way.sv
source/cache_controller.sv
source/io_regs.sv
source/cache_subsystem.sv
tb/mem_model.sv
tb/tb_cache_subsystem.sv

// File: source/cache_controller.sv
`timescale 1ns/10ps

module cache_controller
	import cache_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// CPU side
	input  logic [ADDR_W-1:0] cache_addr,
	input  word_t             cache_wr,
	input  logic              cache_rw,
	input  logic              cache_valid,
	input  logic              flush,
	output word_t             cache_rd,
	output logic              cache_ready,

	// Memory side
	output logic [ADDR_W-1:0] mem_addr,
	output line_t             mem_wr,
	output logic              mem_rw,
	output logic              mem_valid,
	input  line_t             mem_rd,
	input  logic              mem_ready,

	// IO side
	output logic [ADDR_W-1:0] io_addr,
	output word_t             io_wr,
	output logic              io_rw,
	output logic              io_valid,
	input  word_t             io_rd,
	input  logic              io_ready
);

	// Request decode
	logic [TAG_W-1:0]    addr_tag;
	logic [INDEX_W-1:0]  addr_index;
	logic [OFFSET_W-1:0] addr_offset;
	logic                io_sel;
	logic                cache_req;

	cache_state_t state;
	cache_state_t next_state;

	// Way array connections
	logic [INDEX_W-1:0]  way_index;
	logic [TAG_W-1:0]    way_tag;
	line_t               way_line_wr;
	logic                way_dirty_wr;
	logic [NUM_WAYS-1:0] way_we;
	logic [NUM_WAYS-1:0] way_clr;
	line_t               line_rd [NUM_WAYS];
	logic [TAG_W-1:0]    tag_rd [NUM_WAYS];
	logic [NUM_WAYS-1:0] dirty_rd;
	logic [NUM_WAYS-1:0] hit;

	logic [NUM_SETS-1:0] lru;        // Way to replace next, per set
	logic                hit_any;
	logic                hit_way;
	logic                victim;
	logic                flush_way;
	logic                any_dirty;
	logic                flush_last;
	logic [INDEX_W-1:0]  flush_set;
	logic                mem_gap;    // Valid low for a cycle after each ready
	logic                mem_done;
	logic                hit_done;
	logic                flush_done;
	line_t               hit_line;
	line_t               merged_line;
	word_t               hit_word;

	assign addr_tag = cache_addr[ADDR_W-1 -: TAG_W];
	assign addr_index = cache_addr[OFFSET_W +: INDEX_W];
	assign addr_offset = cache_addr[OFFSET_W-1:0];
	assign io_sel = cache_addr[IO_SEL_BIT];
	assign cache_req = cache_valid & ~io_sel;

	// -------------------------------------------------------------------
	// Ways
	// -------------------------------------------------------------------

	assign way_index = (state == FLUSH) ? flush_set : addr_index;
	assign way_tag = addr_tag;
	assign way_line_wr = (state == ALLOCATE) ? mem_rd : merged_line;
	assign way_dirty_wr = (state == COMPARE_TAG);  // Write hit marks dirty, fill is clean

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign way_we[w] = ((state == COMPARE_TAG) & cache_rw & hit[w]) |
			((state == ALLOCATE) & mem_done & (victim == 1'(w)));
		assign way_clr[w] = (state == FLUSH) & mem_done & (flush_way == 1'(w));

		cache_way i_way (
			.clk         (clk),
			.rst_n       (rst_n),
			.index       (way_index),
			.tag_in      (way_tag),
			.line_wr     (way_line_wr),
			.dirty_wr    (way_dirty_wr),
			.write_en    (way_we[w]),
			.clear_dirty (way_clr[w]),
			.line_rd     (line_rd[w]),
			.dirty_rd    (dirty_rd[w]),
			.tag_rd      (tag_rd[w]),
			.hit         (hit[w])
		);
	end

	assign hit_any = |hit;
	assign hit_way = hit[1];
	assign victim = lru[addr_index];
	assign any_dirty = |dirty_rd;
	assign flush_way = ~dirty_rd[0];  // Way 0 first when both dirty
	assign flush_last = (flush_set == INDEX_W'(NUM_SETS - 1));

	// Word select and write merge
	assign hit_line = line_rd[hit_way];
	assign hit_word = hit_line[addr_offset * DATA_W +: DATA_W];

	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (addr_offset == OFFSET_W'(w))
				merged_line[w * DATA_W +: DATA_W] = cache_wr;
			else
				merged_line[w * DATA_W +: DATA_W] = hit_line[w * DATA_W +: DATA_W];
		end
	end

	// -------------------------------------------------------------------
	// State machine
	// -------------------------------------------------------------------

	assign mem_done = mem_valid & mem_ready;
	assign hit_done = (state == COMPARE_TAG) & hit_any;
	assign flush_done = (state == FLUSH) & ~any_dirty & flush_last;

	always_comb begin
		next_state = state;
		unique case (state)
			IDLE: begin
				if (cache_req)
					next_state = flush ? FLUSH : COMPARE_TAG;
			end
			COMPARE_TAG: begin
				if (hit_any)
					next_state = IDLE;
				else if (dirty_rd[victim])
					next_state = WRITE_BACK;  // Victim must go out first
				else
					next_state = ALLOCATE;
			end
			WRITE_BACK: begin
				if (mem_done)
					next_state = ALLOCATE;
			end
			ALLOCATE: begin
				if (mem_done)
					next_state = ALLOCATE_WAIT;
			end
			ALLOCATE_WAIT: next_state = COMPARE_TAG;  // Retry now hits
			FLUSH: begin
				if (flush_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_gap <= 1'b0;
			flush_set <= '0;
			lru <= '0;
		end else begin
			state <= next_state;
			mem_gap <= mem_done;
			if (state == IDLE)
				flush_set <= '0;
			else if (state == FLUSH && !any_dirty && !flush_last)
				flush_set <= flush_set + 1'b1;  // Set clean, move on
			if (hit_done)
				lru[addr_index] <= ~hit_way;  // Other way becomes the victim
		end
	end

	// -------------------------------------------------------------------
	// Memory port
	// -------------------------------------------------------------------

	assign mem_valid = ~mem_gap & ((state == WRITE_BACK) | (state == ALLOCATE) |
		((state == FLUSH) & any_dirty));
	assign mem_rw = (state == WRITE_BACK) | ((state == FLUSH) & any_dirty);
	assign mem_wr = (state == FLUSH) ? line_rd[flush_way] : line_rd[victim];

	always_comb begin
		unique case (state)
			WRITE_BACK: mem_addr = {tag_rd[victim], addr_index, {OFFSET_W{1'b0}}};
			FLUSH:      mem_addr = {tag_rd[flush_way], flush_set, {OFFSET_W{1'b0}}};
			default:    mem_addr = {addr_tag, addr_index, {OFFSET_W{1'b0}}};
		endcase
	end

	// IO bypass, no state involved
	assign io_addr = cache_addr;
	assign io_wr = cache_wr;
	assign io_rw = cache_rw & io_sel;
	assign io_valid = cache_valid & io_sel;

	assign cache_rd = io_sel ? io_rd : hit_word;
	assign cache_ready = io_sel ? io_ready : (hit_done | flush_done);

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

	// -------------------------------------------------------------------
	// Address geometry
	// -------------------------------------------------------------------

	// Word address seen by the CPU
	localparam int ADDR_W = 28;

	localparam int DATA_W = 32;         // One CPU word
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_W = DATA_W * WORDS_PER_LINE;

	// Address = {tag, index, offset}
	localparam int OFFSET_W = 3;
	localparam int INDEX_W = 10;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;  // 15

	// -------------------------------------------------------------------
	// Cache organisation
	// -------------------------------------------------------------------

	localparam int NUM_SETS = 1 << INDEX_W;
	localparam int NUM_WAYS = 2;        // One LRU bit per set, so two ways only

	// IO window
	localparam int IO_SEL_BIT = 27;     // Set means bypass the cache
	localparam int IO_REGS = 4;

	// -------------------------------------------------------------------
	// Types
	// -------------------------------------------------------------------

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [LINE_W-1:0] line_t;

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		COMPARE_TAG,    // Hit check, ready on hit
		WRITE_BACK,     // Dirty victim out to memory
		ALLOCATE,       // Line fill request
		ALLOCATE_WAIT,  // Let the filled line settle
		FLUSH           // Walk every set
	} cache_state_t;

endpackage

// File: source/cache_subsystem.sv
`timescale 1ns/10ps

module cache_subsystem
	import cache_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// CPU
	input  logic [ADDR_W-1:0] cache_addr,
	input  word_t             cache_wr,
	input  logic              cache_rw,
	input  logic              cache_valid,
	input  logic              flush,
	output word_t             cache_rd,
	output logic              cache_ready,

	// Main memory
	output logic [ADDR_W-1:0] mem_addr,
	output line_t             mem_wr,
	output logic              mem_rw,
	output logic              mem_valid,
	input  line_t             mem_rd,
	input  logic              mem_ready
);

	// Controller to IO bank
	logic [ADDR_W-1:0] io_addr;
	word_t             io_wr;
	logic              io_rw;
	logic              io_valid;
	word_t             io_rd;
	logic              io_ready;

	cache_controller i_controller (
		.clk         (clk),
		.rst_n       (rst_n),
		.cache_addr  (cache_addr),
		.cache_wr    (cache_wr),
		.cache_rw    (cache_rw),
		.cache_valid (cache_valid),
		.flush       (flush),
		.cache_rd    (cache_rd),
		.cache_ready (cache_ready),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.mem_rw      (mem_rw),
		.mem_valid   (mem_valid),
		.mem_rd      (mem_rd),
		.mem_ready   (mem_ready),
		.io_addr     (io_addr),
		.io_wr       (io_wr),
		.io_rw       (io_rw),
		.io_valid    (io_valid),
		.io_rd       (io_rd),
		.io_ready    (io_ready)
	);

	io_regs i_io_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.io_addr  (io_addr),
		.io_wr    (io_wr),
		.io_rw    (io_rw),
		.io_valid (io_valid),
		.io_rd    (io_rd),
		.io_ready (io_ready)
	);

endmodule

// File: source/cache_way.sv
`timescale 1ns/10ps

module cache_way
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic [INDEX_W-1:0] index,
	input  logic [TAG_W-1:0]   tag_in,
	input  line_t              line_wr,
	input  logic               dirty_wr,
	input  logic               write_en,
	input  logic               clear_dirty,
	output line_t              line_rd,
	output logic               dirty_rd,
	output logic [TAG_W-1:0]   tag_rd,
	output logic               hit
);

	// Storage, one entry per set
	line_t             data_mem [NUM_SETS];
	logic [TAG_W-1:0]  tag_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;

	// -------------------------------------------------------------------
	// Line and tag store
	// -------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (write_en) begin
			data_mem[index] <= line_wr;
			tag_mem[index] <= tag_in;
		end
	end

	// Status bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (write_en) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= dirty_wr;
		end else if (clear_dirty) begin
			dirty_bits[index] <= 1'b0;  // Flush keeps the line valid
		end
	end

	// -------------------------------------------------------------------
	// Lookup
	// -------------------------------------------------------------------

	assign line_rd = data_mem[index];
	assign tag_rd = tag_mem[index];
	assign dirty_rd = dirty_bits[index];

	// Tag only counts once the entry was filled
	assign hit = valid_bits[index] && (tag_mem[index] == tag_in);

endmodule

// File: source/io_regs.sv
`timescale 1ns/10ps

module io_regs
	import cache_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [ADDR_W-1:0] io_addr,
	input  word_t             io_wr,
	input  logic              io_rw,
	input  logic              io_valid,
	output word_t             io_rd,
	output logic              io_ready
);

	word_t regs [IO_REGS];
	logic [$clog2(IO_REGS)-1:0] sel;
	logic valid_q;
	logic start;

	assign sel = io_addr[$clog2(IO_REGS)-1:0];   // Low bits pick the register
	assign start = io_valid & ~valid_q;          // First cycle of a request

	// -------------------------------------------------------------------
	// Register bank and ready pulse
	// -------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			io_ready <= 1'b0;
			for (int i = 0; i < IO_REGS; i++)
				regs[i] <= '0;
		end else begin
			valid_q <= io_valid;
			io_ready <= start;
			if (start && io_rw)
				regs[sel] <= io_wr;
		end
	end

	// Address is held until ready, so a plain mux suffices
	assign io_rd = regs[sel];

endmodule

// File: tb/mem_model.sv
`timescale 1ns/10ps

module mem_model
	import cache_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [ADDR_W-1:0]          mem_addr,
	input  line_t                      mem_wr,
	input  logic                       mem_rw,
	input  logic                       mem_valid,
	output line_t                      mem_rd,
	output logic                       mem_ready,
	input  logic [ADDR_W-OFFSET_W-1:0] peek_addr,   // Line lookup for the end checks
	output line_t                      peek_line
);

	line_t lines [logic [ADDR_W-OFFSET_W-1:0]];     // Only lines written so far
	int unsigned delay_seed = 34003;
	int unsigned wait_cnt;
	logic busy;

	// Untouched words carry a pattern of their own address
	function automatic word_t fill_word(input logic [ADDR_W-1:0] a);
		return {4'h6, a} ^ 32'hA5C3_0F1E;
	endfunction

	function automatic line_t line_at(input logic [ADDR_W-OFFSET_W-1:0] la);
		line_t l;
		if (lines.exists(la))
			return lines[la];
		for (int w = 0; w < WORDS_PER_LINE; w++)
			l[w * DATA_W +: DATA_W] = fill_word({la, OFFSET_W'(w)});
		return l;
	endfunction

	function automatic int unsigned next_delay();
		delay_seed = delay_seed * 32'd1664525 + 32'd1013904223;
		return (delay_seed >> 16) % 6;   // 0 to 5 extra cycles
	endfunction

	// -------------------------------------------------------------------
	// Request handling, one line per transfer
	// -------------------------------------------------------------------

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			mem_rd <= '0;
			peek_line <= '0;
			busy <= 1'b0;
			wait_cnt <= 0;
		end else begin
			mem_ready <= 1'b0;
			if (mem_valid && !busy && !mem_ready) begin
				busy <= 1'b1;
				wait_cnt <= next_delay();
			end else if (busy && wait_cnt != 0) begin
				wait_cnt <= wait_cnt - 1;
			end else if (busy) begin
				busy <= 1'b0;
				mem_ready <= 1'b1;   // Single cycle pulse
				if (mem_rw)
					lines[mem_addr[ADDR_W-1:OFFSET_W]] = mem_wr;
				else
					mem_rd <= line_at(mem_addr[ADDR_W-1:OFFSET_W]);
			end
			peek_line <= line_at(peek_addr);
		end
	end

endmodule

// File: tb/tb_cache_subsystem.sv
`timescale 1ns/10ps

module tb_cache_subsystem
	import cache_pkg::*;
();

	localparam int MAX_WAIT = 2000;
	localparam int FLUSH_WAIT = 20000;

	logic                       clk = 1'b0;
	logic                       rst_n;
	logic [ADDR_W-1:0]          cache_addr;
	word_t                      cache_wr;
	logic                       cache_rw;
	logic                       cache_valid;
	logic                       flush;
	word_t                      cache_rd;
	logic                       cache_ready;
	logic [ADDR_W-1:0]          mem_addr;
	line_t                      mem_wr;
	logic                       mem_rw;
	logic                       mem_valid;
	line_t                      mem_rd;
	logic                       mem_ready;
	logic [ADDR_W-OFFSET_W-1:0] peek_addr;
	line_t                      peek_line;

	// Reference state
	word_t ref_mem [logic [ADDR_W-1:0]];
	word_t ref_io [IO_REGS] = '{default: '0};
	logic [TAG_W-1:0] newest_tag [NUM_SETS];    // Two most recent tags per set
	logic [TAG_W-1:0] older_tag [NUM_SETS];
	logic [NUM_SETS-1:0] newest_vld = '0;
	logic [NUM_SETS-1:0] older_vld = '0;
	logic [TAG_W-1:0] tag_pool [4] = '{15'h0001, 15'h0A5C, 15'h1F00, 15'h3333};
	logic [INDEX_W-1:0] index_pool [8] = '{10'd0, 10'd1, 10'd5, 10'd100,
		10'd513, 10'd777, 10'd1022, 10'd1023};

	int unsigned seed = 34003;
	int word_errs = 0;
	int line_errs = 0;
	int flag_errs = 0;
	int timeouts = 0;
	logic timed_out = 1'b0;
	logic in_io = 1'b0;
	logic io_mem_seen = 1'b0;

	always #5 clk = ~clk;

	cache_subsystem i_dut (.*);
	mem_model i_mem (.*);

	// Memory must stay quiet while the IO window is in use
	always @(posedge clk) begin
		if (in_io && mem_valid)
			io_mem_seen <= 1'b1;
	end

	// -------------------------------------------------------------------
	// Model helpers
	// -------------------------------------------------------------------

	function automatic int unsigned next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed >> 8;
	endfunction

	function automatic word_t expected_word(input logic [ADDR_W-1:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return {4'h6, a} ^ 32'hA5C3_0F1E;   // Background of main memory
	endfunction

	function automatic logic [ADDR_W-1:0] random_cache_addr();
		logic [TAG_W-1:0] t;
		logic [INDEX_W-1:0] i;
		t = tag_pool[2'(next_random())];
		i = index_pool[3'(next_random())];
		return {t, i, OFFSET_W'(next_random())};
	endfunction

	function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
		logic [TAG_W-1:0] t;
		logic [INDEX_W-1:0] i;
		t = a[ADDR_W-1 -: TAG_W];
		i = a[OFFSET_W +: INDEX_W];
		return (newest_vld[i] && newest_tag[i] == t) || (older_vld[i] && older_tag[i] == t);
	endfunction

	// LRU order of one set after an access
	function automatic void note_access(input logic [ADDR_W-1:0] a);
		logic [TAG_W-1:0] t;
		logic [INDEX_W-1:0] i;
		t = a[ADDR_W-1 -: TAG_W];
		i = a[OFFSET_W +: INDEX_W];
		if (!(newest_vld[i] && newest_tag[i] == t)) begin
			older_tag[i] = newest_tag[i];
			older_vld[i] = newest_vld[i];
			newest_tag[i] = t;
			newest_vld[i] = 1'b1;
		end
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			word_errs++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_line(input string what, input line_t got, input line_t exp);
		if (got !== exp) begin
			line_errs++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// -------------------------------------------------------------------
	// CPU requests
	// -------------------------------------------------------------------

	task automatic drive_request(input logic [ADDR_W-1:0] a, input logic rw, input word_t wdata,
		input logic fl, input int limit, output word_t rdata, output int cycles);
		rdata = '0;
		cycles = 0;
		if (timed_out)
			return;
		@(posedge clk);
		cache_addr <= a;
		cache_wr <= wdata;
		cache_rw <= rw;
		flush <= fl;
		cache_valid <= 1'b1;
		do begin
			@(posedge clk);
			cycles++;
		end while (!cache_ready && cycles < limit);
		if (!cache_ready) begin
			$display("Timeout: cache_ready did not come within %0d cycles, address %h", limit, a);
			timeouts++;
			timed_out = 1'b1;
		end
		rdata = cache_rd;
		cache_valid <= 1'b0;
		flush <= 1'b0;
		cache_rw <= 1'b0;
	endtask

	task automatic cached_access(input logic [ADDR_W-1:0] a, input logic rw, input word_t wdata);
		word_t got;
		int cycles;
		logic expect_hit;
		expect_hit = predict_hit(a);
		drive_request(a, rw, wdata, 1'b0, MAX_WAIT, got, cycles);
		if (timed_out)
			return;
		check_bit("hit with ready one cycle after valid", cycles == 2, expect_hit);
		if (rw)
			ref_mem[a] = wdata;
		else
			check_word("cache read", got, expected_word(a));
		note_access(a);
	endtask

	task automatic io_access(input logic [1:0] sel, input logic rw, input word_t wdata);
		word_t got;
		int cycles;
		drive_request({1'b1, 25'(next_random()), sel}, rw, wdata, 1'b0, MAX_WAIT, got, cycles);
		if (timed_out)
			return;
		check_bit("io ready one cycle after valid", cycles == 2, 1'b1);
		if (rw)
			ref_io[sel] = wdata;
		else
			check_word("io read", got, ref_io[sel]);
	endtask

	// Every line touched must sit in main memory after a flush
	task automatic compare_memory();
		logic [ADDR_W-OFFSET_W-1:0] la;
		line_t exp;
		bit checked [logic [ADDR_W-OFFSET_W-1:0]];
		foreach (ref_mem[a]) begin
			la = a[ADDR_W-1:OFFSET_W];
			if (!checked.exists(la)) begin
				checked[la] = 1'b1;
				for (int w = 0; w < WORDS_PER_LINE; w++)
					exp[w * DATA_W +: DATA_W] = expected_word({la, OFFSET_W'(w)});
				@(posedge clk);
				peek_addr <= la;
				repeat (2) @(posedge clk);   // Peek output is registered
				check_line("memory line after flush", peek_line, exp);
			end
		end
	endtask

	// -------------------------------------------------------------------
	// Test sequence
	// -------------------------------------------------------------------

	initial begin
		logic [ADDR_W-1:0] a;
		word_t d;
		int unsigned r;
		int cycles;
		int total;
		cache_addr <= '0;
		cache_wr <= '0;
		cache_rw <= 1'b0;
		cache_valid <= 1'b0;
		flush <= 1'b0;
		peek_addr <= '0;
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			check_bit("cache_ready while idle", cache_ready, 1'b0);
			check_bit("mem_valid while idle", mem_valid, 1'b0);
		end

		for (int i = 0; i < 8; i++) begin
			a = random_cache_addr();
			cached_access(a, 1'b1, next_random());
			cached_access(a, 1'b0, '0);   // Must hit
		end

		for (int i = 0; i < 400; i++) begin
			a = random_cache_addr();
			r = next_random();
			cached_access(a, r[4], next_random());
		end

		drive_request('0, 1'b0, '0, 1'b1, FLUSH_WAIT, d, cycles);
		if (!timed_out)
			compare_memory();

		in_io <= 1'b1;
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			io_access(r[1:0], r[5], next_random());
		end
		for (int s = 0; s < IO_REGS; s++)
			io_access(2'(s), 1'b0, '0);
		in_io <= 1'b0;
		@(posedge clk);
		check_bit("mem_valid during IO accesses", io_mem_seen, 1'b0);

		// Lines stay valid through the flush
		foreach (ref_mem[k])
			cached_access(k, 1'b0, '0);

		total = word_errs + line_errs + flag_errs + timeouts;
		$display("Errors: word %0d, line %0d, flag %0d, timeout %0d, total %0d",
			word_errs, line_errs, flag_errs, timeouts, total);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
